// ==== flist.f ====
+incdir+hw
hw/axi_wb_pkg.sv
hw/wb_mem.sv
hw/axi4_wb_bridge.sv
hw/axi_wb_top.sv
dv/axi_wb_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module axi_wb_tb -f flist.f -o axi_wb_sim

./obj_dir/axi_wb_sim 2>&1 | tee sim.log

if grep -q "Verification passed" sim.log; then
	echo "simulation run succeeded"
else
	echo "simulation run did not succeed, see sim.log"
	exit 1
fi

// ==== dv/axi_wb_tb.sv ====
// Table-driven testbench for the AXI to Wishbone bridge top; run through run.sh with Verilator.
`timescale 1ns/1ps
`include "axi_wb_config.svh"

module axi_wb_tb;

	typedef struct packed {
		logic              wr;
		axi_wb_pkg::addr_t addr;
		axi_wb_pkg::len_t  len;
		axi_wb_pkg::strb_t strb;
	} row_t;

	logic axi_clk;
	logic rstn;
	axi_wb_pkg::addr_t araddr_i;
	axi_wb_pkg::len_t  arlen_i;
	logic              arvalid_i;
	logic              arready_o;
	axi_wb_pkg::data_t rdata_o;
	axi_wb_pkg::resp_t rresp_o;
	logic              rlast_o;
	logic              rvalid_o;
	logic              rready_i;
	axi_wb_pkg::addr_t awaddr_i;
	axi_wb_pkg::len_t  awlen_i;
	logic              awvalid_i;
	logic              awready_o;
	axi_wb_pkg::data_t wdata_i;
	axi_wb_pkg::strb_t wstrb_i;
	logic              wlast_i;
	logic              wvalid_i;
	logic              wready_o;
	axi_wb_pkg::resp_t bresp_o;
	logic              bvalid_o;
	logic              bready_i;

	row_t              rows[$];
	logic              table_ready;
	axi_wb_pkg::data_t ref_mem [`AXI_WB_MEM_WORDS]; // expected memory contents.

	axi_wb_top u_dut (
		.axi_clk   (axi_clk),   .rstn      (rstn),
		.araddr_i  (araddr_i),  .arlen_i   (arlen_i),
		.arvalid_i (arvalid_i), .arready_o (arready_o),
		.rdata_o   (rdata_o),   .rresp_o   (rresp_o),
		.rlast_o   (rlast_o),   .rvalid_o  (rvalid_o),  .rready_i (rready_i),
		.awaddr_i  (awaddr_i),  .awlen_i   (awlen_i),
		.awvalid_i (awvalid_i), .awready_o (awready_o),
		.wdata_i   (wdata_i),   .wstrb_i   (wstrb_i),   .wlast_i  (wlast_i),
		.wvalid_i  (wvalid_i),  .wready_o  (wready_o),
		.bresp_o   (bresp_o),   .bvalid_o  (bvalid_o),  .bready_i (bready_i)
	);

	always #10 axi_clk = ~axi_clk; // 20 ns period.

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_data(input string name, input axi_wb_pkg::data_t exp,
	                          input axi_wb_pkg::data_t act);
		if (act !== exp)
			fail_run($sformatf("CHECK FAILED %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_resp(input string name, input axi_wb_pkg::resp_t exp,
	                          input axi_wb_pkg::resp_t act);
		if (act !== exp)
			fail_run($sformatf("CHECK FAILED %s expected %h got %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("CHECK FAILED %s expected %h got %h", name, exp, act));
	endtask

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic step_cycle();
		@(posedge axi_clk);
		#1; // drive just after the edge.
	endtask

	function automatic int word_index(input axi_wb_pkg::addr_t a, input int beat);
		return (int'(a >> 2) + beat) % `AXI_WB_MEM_WORDS; // wraps at the depth.
	endfunction

	function automatic void add_row(input logic wr, input axi_wb_pkg::addr_t addr,
	                                input axi_wb_pkg::len_t len, input axi_wb_pkg::strb_t strb);
		row_t r;
		r.wr   = wr;
		r.addr = addr;
		r.len  = len;
		r.strb = strb;
		rows.push_back(r);
	endfunction

	task automatic write_burst(input row_t r);
		int                beat;
		int                idx;
		axi_wb_pkg::data_t data;
		awaddr_i  = r.addr;
		awlen_i   = r.len;
		awvalid_i = 1'b1;
		forever begin
			@(negedge axi_clk);
			if (awready_o)
				break;
			step_cycle();
		end
		step_cycle();
		awvalid_i = 1'b0;
		for (beat = 0; beat <= int'(r.len); beat++) begin
			data      = $urandom;
			wdata_i   = data;
			wstrb_i   = r.strb;
			wlast_i   = (beat == int'(r.len));
			wvalid_i  = 1'b1;
			forever begin
				@(negedge axi_clk);
				if (wready_o)
					break;
				step_cycle();
			end
			idx = word_index(r.addr, beat);
			for (int b = 0; b < `AXI_WB_DATA_W / 8; b++) begin
				if (r.strb[b])
					ref_mem[idx][8*b +: 8] = data[8*b +: 8];
			end
			step_cycle();
			wvalid_i = 1'b0;
			wlast_i  = 1'b0;
		end
		forever begin
			bready_i = ($urandom % 3) == 0; // stall B about two cycles in three.
			@(negedge axi_clk);
			if (bvalid_o && bready_i)
				break;
			step_cycle();
		end
		check_resp("bresp_o", axi_wb_pkg::RESP_OKAY, bresp_o);
		step_cycle();
		bready_i = 1'b0;
		@(negedge axi_clk);
		check_flag("bvalid_o", 1'b0, bvalid_o); // exactly one response.
		step_cycle();
	endtask

	task automatic read_burst(input row_t r);
		int beat;
		araddr_i  = r.addr;
		arlen_i   = r.len;
		arvalid_i = 1'b1;
		forever begin
			@(negedge axi_clk);
			if (arready_o)
				break;
			step_cycle();
		end
		step_cycle();
		arvalid_i = 1'b0;
		beat = 0;
		while (beat <= int'(r.len)) begin
			rready_i = ($urandom % 4) != 0;
			@(negedge axi_clk);
			if (rvalid_o && rready_i) begin
				check_data("rdata_o", ref_mem[word_index(r.addr, beat)], rdata_o);
				check_resp("rresp_o", axi_wb_pkg::RESP_OKAY, rresp_o);
				check_flag("rlast_o", beat == int'(r.len), rlast_o);
				beat++;
			end
			step_cycle();
		end
		rready_i = 1'b0;
		@(negedge axi_clk);
		check_flag("rvalid_o", 1'b0, rvalid_o); // no extra beats.
		step_cycle();
	endtask

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin : watchdog
		int budget;
		budget = 500; // margin for address phases and reset.
		wait (table_ready);
		foreach (rows[i])
			budget += (int'(rows[i].len) + 1) * (`AXI_WB_WAIT_STATES + 20);
		repeat (budget) @(posedge axi_clk);
		fail_run($sformatf("timeout, transactions did not finish in %0d cycles", budget));
	end

	// ------------------------------
	// main sequence
	// ------------------------------
	initial begin
		void'($urandom(88));
		axi_clk   = 1'b0;
		rstn      = 1'b0;
		araddr_i  = '0;
		arlen_i   = '0;
		arvalid_i = 1'b0;
		rready_i  = 1'b0;
		awaddr_i  = '0;
		awlen_i   = '0;
		awvalid_i = 1'b0;
		wdata_i   = '0;
		wstrb_i   = '0;
		wlast_i   = 1'b0;
		wvalid_i  = 1'b0;
		bready_i  = 1'b0;
		table_ready = 1'b0;

		// kind, byte address, length minus one, strobe.
		add_row(1'b1, 32'h0000_0010, 4'd0,  4'hF); // single beat.
		add_row(1'b0, 32'h0000_0010, 4'd0,  4'hF);
		add_row(1'b1, 32'h0000_0100, 4'd15, 4'hF); // full 16-beat burst.
		add_row(1'b0, 32'h0000_0100, 4'd15, 4'hF);
		add_row(1'b1, 32'h0000_0104, 4'd3,  4'h5); // partial strobes.
		add_row(1'b1, 32'h0000_0120, 4'd1,  4'hA);
		add_row(1'b0, 32'h0000_0100, 4'd11, 4'hF);
		add_row(1'b1, 32'h0000_07F8, 4'd3,  4'hF); // crosses the depth.
		add_row(1'b0, 32'h0000_03F8, 4'd3,  4'hF);
		add_row(1'b1, 32'h0000_0400, 4'd0,  4'h6); // aliases word 0.
		add_row(1'b0, 32'h0000_0000, 4'd1,  4'hF);
		add_row(1'b1, 32'h0000_013C, 4'd0,  4'h8);
		add_row(1'b0, 32'h0000_013C, 4'd0,  4'hF);
		table_ready = 1'b1;

		repeat (2) @(posedge axi_clk);
		#1;
		rstn = 1'b1;
		@(negedge axi_clk);
		check_flag("arready_o", 1'b1, arready_o);
		check_flag("awready_o", 1'b1, awready_o);
		check_flag("rvalid_o", 1'b0, rvalid_o);
		check_flag("wready_o", 1'b0, wready_o);
		check_flag("bvalid_o", 1'b0, bvalid_o);
		step_cycle();

		foreach (rows[i]) begin
			if (rows[i].wr)
				write_burst(rows[i]);
			else
				read_burst(rows[i]);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== hw/axi_wb_top.sv ====
// Top level joining the AXI to Wishbone bridge and its memory; the testbench DUT.
`timescale 1ns/1ps

module axi_wb_top (
	input  logic              axi_clk,
	input  logic              rstn,

	// read address channel
	input  axi_wb_pkg::addr_t araddr_i,
	input  axi_wb_pkg::len_t  arlen_i,
	input  logic              arvalid_i,
	output logic              arready_o,

	// read data channel
	output axi_wb_pkg::data_t rdata_o,
	output axi_wb_pkg::resp_t rresp_o,
	output logic              rlast_o,
	output logic              rvalid_o,
	input  logic              rready_i,

	// write address channel
	input  axi_wb_pkg::addr_t awaddr_i,
	input  axi_wb_pkg::len_t  awlen_i,
	input  logic              awvalid_i,
	output logic              awready_o,

	// write data and response
	input  axi_wb_pkg::data_t wdata_i,
	input  axi_wb_pkg::strb_t wstrb_i,
	input  logic              wlast_i,
	input  logic              wvalid_i,
	output logic              wready_o,
	output axi_wb_pkg::resp_t bresp_o,
	output logic              bvalid_o,
	input  logic              bready_i
);

	// ------------------------------
	// wishbone bus
	// ------------------------------
	axi_wb_pkg::addr_t wb_adr;
	axi_wb_pkg::data_t wb_dat_w;
	axi_wb_pkg::data_t wb_dat_r;
	axi_wb_pkg::strb_t wb_sel;
	logic              wb_we;
	logic              wb_cyc;
	logic              wb_stb;
	logic              wb_ack;

	axi4_wb_bridge u_bridge (
		.axi_clk   (axi_clk),   .rstn      (rstn),
		.araddr_i  (araddr_i),  .arlen_i   (arlen_i),
		.arvalid_i (arvalid_i), .arready_o (arready_o),
		.rdata_o   (rdata_o),   .rresp_o   (rresp_o),
		.rlast_o   (rlast_o),   .rvalid_o  (rvalid_o),  .rready_i (rready_i),
		.awaddr_i  (awaddr_i),  .awlen_i   (awlen_i),
		.awvalid_i (awvalid_i), .awready_o (awready_o),
		.wdata_i   (wdata_i),   .wstrb_i   (wstrb_i),   .wlast_i  (wlast_i),
		.wvalid_i  (wvalid_i),  .wready_o  (wready_o),
		.bresp_o   (bresp_o),   .bvalid_o  (bvalid_o),  .bready_i (bready_i),
		.wb_adr_o  (wb_adr),    .wb_dat_w_o (wb_dat_w), .wb_sel_o (wb_sel),
		.wb_we_o   (wb_we),     .wb_cyc_o  (wb_cyc),    .wb_stb_o (wb_stb),
		.wb_dat_r_i (wb_dat_r), .wb_ack_i  (wb_ack)
	);

	wb_mem u_mem (
		.axi_clk    (axi_clk),  .rstn       (rstn),
		.wb_adr_i   (wb_adr),   .wb_dat_w_i (wb_dat_w),
		.wb_sel_i   (wb_sel),   .wb_we_i    (wb_we),
		.wb_cyc_i   (wb_cyc),   .wb_stb_i   (wb_stb),
		.wb_dat_r_o (wb_dat_r), .wb_ack_o   (wb_ack)
	);

endmodule

// ==== hw/axi4_wb_bridge.sv ====
// AXI4 slave to Wishbone classic master bridge, one INCR burst at a time; instantiate in the top.
`timescale 1ns/1ps
`include "axi_wb_config.svh"

module axi4_wb_bridge (
	input  logic                  axi_clk,
	input  logic                  rstn,

	// read address channel
	input  axi_wb_pkg::addr_t     araddr_i,
	input  axi_wb_pkg::len_t      arlen_i,
	input  logic                  arvalid_i,
	output logic                  arready_o,

	// read data channel
	output axi_wb_pkg::data_t     rdata_o,
	output axi_wb_pkg::resp_t     rresp_o,
	output logic                  rlast_o,
	output logic                  rvalid_o,
	input  logic                  rready_i,

	// write address channel
	input  axi_wb_pkg::addr_t     awaddr_i,
	input  axi_wb_pkg::len_t      awlen_i,
	input  logic                  awvalid_i,
	output logic                  awready_o,

	// write data channel
	input  axi_wb_pkg::data_t     wdata_i,
	input  axi_wb_pkg::strb_t     wstrb_i,
	input  logic                  wlast_i,
	input  logic                  wvalid_i,
	output logic                  wready_o,

	// write response channel
	output axi_wb_pkg::resp_t     bresp_o,
	output logic                  bvalid_o,
	input  logic                  bready_i,

	// wishbone master
	output axi_wb_pkg::addr_t     wb_adr_o,
	output axi_wb_pkg::data_t     wb_dat_w_o,
	output axi_wb_pkg::strb_t     wb_sel_o,
	output logic                  wb_we_o,
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	input  axi_wb_pkg::data_t     wb_dat_r_i,
	input  logic                  wb_ack_i
);

	localparam int BEAT_BYTES = `AXI_WB_DATA_W / 8;

	axi_wb_pkg::bridge_state_t state;

	axi_wb_pkg::addr_t addr_q;   // current beat address.
	axi_wb_pkg::len_t  len_q;
	axi_wb_pkg::len_t  beat_q;   // beats completed so far.
	axi_wb_pkg::data_t rdata_q;
	axi_wb_pkg::data_t wdata_q;
	axi_wb_pkg::strb_t sel_q;
	logic              last_q;   // write beat in flight is the final one.

	logic final_beat;
	logic ar_fire;
	logic aw_fire;
	logic w_fire;
	logic r_fire;
	logic bus_active;

	assign final_beat = (beat_q == len_q);
	assign ar_fire    = arvalid_i && arready_o;
	assign aw_fire    = awvalid_i && awready_o;
	assign w_fire     = wvalid_i && wready_o;
	assign r_fire     = rvalid_o && rready_i;
	assign bus_active = (state == axi_wb_pkg::RD_BUS) || (state == axi_wb_pkg::WR_BUS);

	// ------------------------------
	// control FSM
	// ------------------------------
	always_ff @(posedge axi_clk) begin
		if (!rstn) begin
			state  <= axi_wb_pkg::IDLE;
			beat_q <= '0;
			last_q <= 1'b0;
		end else begin
			case (state)
				axi_wb_pkg::IDLE: begin
					if (ar_fire) begin // reads win a tie.
						beat_q <= '0;
						state  <= axi_wb_pkg::RD_BUS;
					end else if (aw_fire) begin
						beat_q <= '0;
						state  <= axi_wb_pkg::WR_DATA;
					end
				end
				axi_wb_pkg::RD_BUS: begin
					if (wb_ack_i)
						state <= axi_wb_pkg::RD_RESP;
				end
				axi_wb_pkg::RD_RESP: begin
					if (r_fire) begin
						if (final_beat) begin
							state <= axi_wb_pkg::IDLE;
						end else begin
							beat_q <= beat_q + 1'b1;
							state  <= axi_wb_pkg::RD_BUS;
						end
					end
				end
				axi_wb_pkg::WR_DATA: begin
					if (w_fire) begin
						last_q <= final_beat; // beat count marks the last beat.
						state  <= axi_wb_pkg::WR_BUS;
					end
				end
				axi_wb_pkg::WR_BUS: begin
					if (wb_ack_i) begin
						if (last_q) begin
							state <= axi_wb_pkg::WR_RESP;
						end else begin
							beat_q <= beat_q + 1'b1;
							state  <= axi_wb_pkg::WR_DATA;
						end
					end
				end
				axi_wb_pkg::WR_RESP: begin
					if (bready_i)
						state <= axi_wb_pkg::IDLE;
				end
				default: state <= axi_wb_pkg::IDLE;
			endcase
		end
	end

	// ------------------------------
	// address and data path
	// ------------------------------
	always_ff @(posedge axi_clk) begin
		if (ar_fire) begin
			addr_q <= araddr_i;
			len_q  <= arlen_i;
			sel_q  <= '1; // reads take every byte.
		end else if (aw_fire) begin
			addr_q <= awaddr_i;
			len_q  <= awlen_i;
		end else if ((r_fire && !final_beat) ||
		             (state == axi_wb_pkg::WR_BUS && wb_ack_i && !last_q)) begin
			addr_q <= addr_q + axi_wb_pkg::addr_t'(BEAT_BYTES); // next word.
		end
		if (w_fire) begin
			wdata_q <= wdata_i;
			sel_q   <= wstrb_i;
		end
		if (state == axi_wb_pkg::RD_BUS && wb_ack_i)
			rdata_q <= wb_dat_r_i;
	end

	// ------------------------------
	// outputs
	// ------------------------------
	assign arready_o = (state == axi_wb_pkg::IDLE);
	assign awready_o = (state == axi_wb_pkg::IDLE) && !arvalid_i; // no AW accept on a tie.
	assign rvalid_o  = (state == axi_wb_pkg::RD_RESP);
	assign rdata_o   = rdata_q;
	assign rlast_o   = rvalid_o && final_beat;
	assign rresp_o   = axi_wb_pkg::RESP_OKAY;
	assign wready_o  = (state == axi_wb_pkg::WR_DATA);
	assign bvalid_o  = (state == axi_wb_pkg::WR_RESP);
	assign bresp_o   = axi_wb_pkg::RESP_OKAY;

	assign wb_adr_o   = addr_q;
	assign wb_dat_w_o = wdata_q;
	assign wb_sel_o   = sel_q;
	assign wb_we_o    = (state == axi_wb_pkg::WR_BUS);
	assign wb_cyc_o   = bus_active;
	assign wb_stb_o   = bus_active;

	// ------------------------------
	// assertions
	// ------------------------------
	// stb holds with a steady address, data and select until the slave acks.
	a_stb_hold: assert property (@(posedge axi_clk) disable iff (!rstn)
		(wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o) &&
		                             $stable(wb_dat_w_o) && $stable(wb_sel_o)))
		else $error("wb_stb_o dropped or its payload changed before the ack");

	a_stb_drop: assert property (@(posedge axi_clk) disable iff (!rstn)
		wb_ack_i |=> !wb_stb_o)
		else $error("wb_stb_o still high in the cycle after the ack");

	// the master must flag the same final beat the length predicts.
	a_wlast_count: assert property (@(posedge axi_clk) disable iff (!rstn)
		w_fire |-> (wlast_i == final_beat))
		else $error("wlast_i disagrees with the burst length");

	a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!rstn)
		(rvalid_o && !rready_i) |=> (rvalid_o && $stable(rdata_o)))
		else $error("read beat dropped or changed under back-pressure");

endmodule

// ==== hw/wb_mem.sv ====
// Wishbone classic slave memory with byte selects and fixed wait states; sits behind the bridge.
`timescale 1ns/1ps
`include "axi_wb_config.svh"

module wb_mem (
	input  logic              axi_clk,
	input  logic              rstn,
	input  axi_wb_pkg::addr_t wb_adr_i,
	input  axi_wb_pkg::data_t wb_dat_w_i,
	input  axi_wb_pkg::strb_t wb_sel_i,
	input  logic              wb_we_i,
	input  logic              wb_cyc_i,
	input  logic              wb_stb_i,
	output axi_wb_pkg::data_t wb_dat_r_o,
	output logic              wb_ack_o
);

	localparam int IDX_W  = $clog2(`AXI_WB_MEM_WORDS);
	localparam int CNT_W  = $clog2(`AXI_WB_WAIT_STATES + 2);
	localparam int LANES  = `AXI_WB_DATA_W / 8;

	axi_wb_pkg::data_t mem [`AXI_WB_MEM_WORDS];

	logic [IDX_W-1:0] idx;     // word address, wraps at the depth.
	logic [CNT_W-1:0] wait_q;
	logic             req;
	logic             fire;    // last wait cycle, access happens now.

	assign idx  = wb_adr_i[IDX_W+1:2];
	assign req  = wb_cyc_i && wb_stb_i && !wb_ack_o;
	assign fire = req && (wait_q == CNT_W'(`AXI_WB_WAIT_STATES));

	// ------------------------------
	// wait counter and ack
	// ------------------------------
	always_ff @(posedge axi_clk) begin
		if (!rstn) begin
			wait_q   <= '0;
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= fire; // single-cycle pulse.
			if (fire || !req)
				wait_q <= '0;
			else
				wait_q <= wait_q + 1'b1;
		end
	end

	// ------------------------------
	// storage
	// ------------------------------
	always_ff @(posedge axi_clk) begin
		if (fire) begin
			wb_dat_r_o <= mem[idx]; // old word, ignored on writes.
			if (wb_we_i) begin
				for (int b = 0; b < LANES; b++) begin
					if (wb_sel_i[b])
						mem[idx][8*b +: 8] <= wb_dat_w_i[8*b +: 8];
				end
			end
		end
	end

	a_ack_in_cycle: assert property (@(posedge axi_clk) disable iff (!rstn)
		wb_ack_o |-> (wb_cyc_i && wb_stb_i))
		else $error("wb_ack_o without an active strobe");

endmodule

// ==== hw/axi_wb_pkg.sv ====
// Shared AXI and Wishbone types for the bridge, memory and testbench; use by scoped name.
`include "axi_wb_config.svh"

package axi_wb_pkg;

	// ------------------------------
	// payload types
	// ------------------------------
	typedef logic [`AXI_WB_ADDR_W-1:0]   addr_t; // byte address.
	typedef logic [`AXI_WB_DATA_W-1:0]   data_t;
	typedef logic [`AXI_WB_DATA_W/8-1:0] strb_t; // one bit per byte lane.

	typedef logic [3:0] len_t; // burst length minus one.
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'b00;

	// ------------------------------
	// bridge FSM
	// ------------------------------
	typedef enum logic [2:0] {
		IDLE,    // waiting for AR or AW.
		RD_BUS,  // wishbone read in flight.
		RD_RESP, // read beat offered on R.
		WR_DATA, // waiting for a W beat.
		WR_BUS,  // wishbone write in flight.
		WR_RESP  // response offered on B.
	} bridge_state_t;

endpackage

// ==== hw/axi_wb_config.svh ====
// Shared width, memory depth and wait-state macros; include in RTL and testbench.
`ifndef AXI_WB_CONFIG_SVH
`define AXI_WB_CONFIG_SVH

// ------------------------------
// bus widths
// ------------------------------
`define AXI_WB_ADDR_W 32 // byte address.
`define AXI_WB_DATA_W 32 // one full beat.

// ------------------------------
// memory model
// ------------------------------
`define AXI_WB_MEM_WORDS 256 // depth in words, power of two.

// cycles between stb rising and ack, minus one.
`define AXI_WB_WAIT_STATES 2

`endif
